/* list.f */
+incdir+.
gopigo_pkg.sv
robot_cmd_if.sv
spi_byte_if.sv
btn_setpoint_stepper.sv
spi_cmd_sequencer.sv
spi_byte_master.sv
btntest_spi_top.sv
tb_spi_assert.sv
tb_btntest_spi.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
  --top-module tb_btntest_spi -f list.f -o sim_tb || exit 1

out="$(./obj_dir/sim_tb)"
echo "$out"

echo "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1

/* tb_btntest_spi.sv */
// ---------------------------------------------------------------------------
// testbench with clock, SPI slave model, setpoint model, test table and checks
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

`include "gopigo_macros.svh"

module tb_btntest_spi import gopigo_pkg::*; ();

  // rst is the clock, clk the reset
  logic  rst;
  logic  clk;
  logic  btn;
  logic  miso;
  logic  sclk;
  logic  mosi;
  logic  ss_n;
  logic  rpi;
  byte_t spi_rx;
  logic  rx_valid;

  // presses, gap cycles, in-order check, name
  int    t_presses[3] = '{270, 60, 18};
  int    t_gap[3]     = '{220, 30, 220};
  bit    t_long[3]    = '{1'b1, 1'b0, 1'b1};
  string t_name[3]    = '{"long_sweep", "short_burst", "long_after_burst"};

  int errors;
  int failed_tests;
  bit rpi_watch;
  // slave side capture
  byte_t       cur_bytes[$];
  byte_t       replies[$];
  logic [39:0] got_frames[$];
  int          got_lens[$];
  byte_t       rep;
  byte_t       rx_sh;
  int          nbit;
  // next miso level of the slave
  logic        miso_nx;
  // model state where sel 3 is the left speed slot
  int          sel;
  logic [15:0] m_dps[2];
  logic [23:0] m_rgb[4];
  logic [39:0] exp_frames[$];
  logic [23:0] newest[6];
  int          n_upd[6];

  btntest_spi_top u_dut (
    .rst           (rst),
    .clk           (clk),
    .btn_i         (btn),
    .miso_i        (miso),
    .sclk_o        (sclk),
    .mosi_o        (mosi),
    .spi_ss_n_o    (ss_n),
    .rpi_running_o (rpi),
    .spi_rx_o      (spi_rx),
    .rx_valid_o    (rx_valid)
  );

  initial begin
    rst = 1'b0;
    forever #2 rst = ~rst;
  end

  task automatic check_eq(input logic [39:0] got, input logic [39:0] exp,
                          input string what);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // slave model gives a new reply at frame start and after each byte
  always @(negedge ss_n) begin
    rep     = byte_t'($urandom);
    miso_nx = rep[7];
    nbit    = 0;
  end

  always @(posedge sclk) begin
    rx_sh = {rx_sh[6:0], mosi};
    nbit++;
    if (nbit == 8) begin
      cur_bytes.push_back(rx_sh);
      replies.push_back(rep);
      nbit = 0;
    end
  end

  always @(negedge sclk) begin
    if (!ss_n) begin
      if (nbit == 0) begin
        rep     = byte_t'($urandom);
        miso_nx = rep[7];
      end else begin
        miso_nx = rep[7-nbit];
      end
    end
  end

  // miso moves on the falling clock edge after the sclk fall
  always @(negedge rst) begin
    miso = miso_nx;
  end

  // frame ends with slave select release
  always @(posedge ss_n) begin
    logic [39:0] f;
    f = '0;
    if (cur_bytes.size() > 0) begin
      foreach (cur_bytes[i])
        f = {f[31:0], cur_bytes[i]};
      got_frames.push_back(f);
      got_lens.push_back(cur_bytes.size());
      cur_bytes.delete();
    end
  end

  // reply byte and rpi_running monitor
  always @(negedge rst) begin
    if (rx_valid) begin
      if (replies.size() == 0) begin
        $display("reply strobe at %0t ns with no byte sent by the slave", $time);
        errors++;
      end else begin
        check_eq(spi_rx, replies.pop_front(), "reply byte");
      end
    end
    if (rpi_watch)
      check_eq(rpi, 1'b1, "rpi_running after reset");
  end

  function automatic logic [7:0] cmd_byte_of(input int fld);
    case (fld)
      0: return `GOPIGO_CMD_DPS_LEFT;
      1: return `GOPIGO_CMD_DPS_RGHT;
      2: return `GOPIGO_CMD_EYE_LEFT;
      3: return `GOPIGO_CMD_EYE_RGHT;
      4: return `GOPIGO_CMD_BLINK_LEFT;
      default: return `GOPIGO_CMD_BLINK_RGHT;
    endcase
  endfunction

  function automatic logic [39:0] frame_of(input int fld, input logic [23:0] v);
    logic [7:0] cmd_b;
    cmd_b = cmd_byte_of(fld);
    // speeds are 4 bytes, colors 5
    if (fld < 2)
      return {8'h00, `GOPIGO_ADDR, cmd_b, v[15:0]};
    return {`GOPIGO_ADDR, cmd_b, v};
  endfunction

  // one press on the model returns fld -1 on the pwm slots
  task automatic predict_press(output int fld, output logic [23:0] v);
    logic [23:0] c;
    fld = -1;
    v   = '0;
    case (sel)
      3: begin
        m_dps[0] = (m_dps[0] >= 900) ? 16'd0 : m_dps[0] + 16'd32;
        fld = 0;
        v   = {8'h00, m_dps[0]};
      end
      4: begin
        m_dps[1] = (m_dps[1] >= 900) ? 16'h8000 : m_dps[1] + 16'd400;
        fld = 1;
        v   = {8'h00, m_dps[1]};
      end
      5, 6, 7, 8: begin
        c = m_rgb[sel-5];
        if (sel == 5)
          c = (c[7:0] >= 64) ? 24'd0 : {c[23:8], c[7:0] + 8'd32};
        else if (sel == 6)
          c = (c[15:8] >= 64) ? 24'd0 : {c[23:16], c[15:8] + 8'd32, c[7:0]};
        else if (sel == 7)
          c = (c[23:16] >= 128) ? 24'd0 : {c[23:16] + 8'd32, c[15:0]};
        else if (c[7:0] >= 128)
          c = 24'd0;
        else
          c = {c[23:16] + 8'd32, c[15:8] + 8'd32, c[7:0] + 8'd32};
        m_rgb[sel-5] = c;
        fld = sel - 3;
        v   = c;
      end
      default: fld = -1;
    endcase
    sel = (sel == 8) ? 0 : sel + 1;
  endtask

  task automatic press_button(input int gap);
    @(negedge rst);
    btn = 1'b1;
    repeat (3) @(negedge rst);
    btn = 1'b0;
    repeat (gap) @(negedge rst);
  endtask

  // link is quiet once ss_n stays high for a while
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 300) begin
      @(negedge rst);
      quiet = ss_n ? quiet + 1 : 0;
    end
  endtask

  task automatic check_newest();
    int cnt[6];
    logic [39:0] last_f[6];
    int fld;
    foreach (got_frames[i]) begin
      fld = 7;
      for (int k = 0; k < 6; k++) begin
        if ((got_lens[i] == 4 && k < 2 && got_frames[i][23:16] == cmd_byte_of(k)) ||
            (got_lens[i] == 5 && k >= 2 && got_frames[i][31:24] == cmd_byte_of(k)))
          fld = k;
      end
      if (fld == 7) begin
        $display("frame with an unknown command byte: %h", got_frames[i]);
        errors++;
      end else begin
        cnt[fld]++;
        last_f[fld] = got_frames[i];
      end
    end
    for (int k = 0; k < 6; k++) begin
      if (cnt[k] > n_upd[k] || (n_upd[k] > 0 && cnt[k] == 0)) begin
        $display("field %0d: %0d frames for %0d updates", k, cnt[k], n_upd[k]);
        errors++;
      end
      if (n_upd[k] > 0)
        check_eq(last_f[k], frame_of(k, newest[k]), "newest frame of a field");
    end
  endtask

  initial begin
    int fld;
    logic [23:0] v;
    int e0;
    void'($urandom(32'h30f3));
    clk = 1'b1;
    btn = 1'b0;
    miso = 1'b0;
    miso_nx = 1'b0;
    errors = 0;
    failed_tests = 0;
    rpi_watch = 1'b0;
    sel = 3;
    m_dps = '{default: '0};
    m_rgb = '{default: '0};
    repeat (2) @(negedge rst);
    check_eq({ss_n, sclk, mosi, rx_valid, rpi}, 5'b10000, "pins in reset");
    clk = 1'b0;
    @(negedge rst);
    check_eq(rpi, 1'b1, "rpi_running after reset");
    rpi_watch = 1'b1;
    for (int t = 0; t < 3; t++) begin
      e0 = errors;
      got_frames.delete();
      got_lens.delete();
      exp_frames.delete();
      n_upd = '{default: 0};
      for (int p = 0; p < t_presses[t]; p++) begin
        predict_press(fld, v);
        press_button(t_gap[t]);
        if (fld >= 0) begin
          exp_frames.push_back(frame_of(fld, v));
          newest[fld] = v;
          n_upd[fld]++;
        end
      end
      wait_idle();
      if (t_long[t]) begin
        check_eq(got_frames.size(), exp_frames.size(), "frame count");
        foreach (exp_frames[i])
          if (i < got_frames.size())
            check_eq(got_frames[i], exp_frames[i], "frame contents");
      end else begin
        check_newest();
      end
      if (errors != e0)
        failed_tests++;
      $display("test %s: %0d presses, %0d frames, %s", t_name[t], t_presses[t],
               got_frames.size(), (errors == e0) ? "ok" : "failed");
    end
    // failures of the bound protocol assertions
    errors += u_dut.u_master.u_assert.fails;
    $display("tests run 3, failed %0d, errors %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // run limit is twice the worst case frame time per press in the table
  initial begin
    longint cyc;
    cyc = 0;
    for (int t = 0; t < 3; t++)
      cyc += t_presses[t] * (6 + 5 * 32 + t_gap[t]) + 400;
    #(cyc * 4 * 2);
    $display("watchdog expired, the run did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* tb_spi_assert.sv */
// ---------------------------------------------------------------------------
// SPI pin protocol assertions, bound into the byte master
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_spi_assert (
  input logic rst,
  input logic clk,
  input logic sclk,
  input logic mosi,
  input logic ss_n,
  input logic rx_done
);

  // number of failed assertions
  int fails = 0;

  // no clock pulses outside a frame
  a_sclk_idle: assert property (@(posedge rst) disable iff (clk) ss_n |-> !sclk)
    else begin
      fails++;
      $error("sclk high while slave select is released");
    end

  // data only moves while sclk is low
  a_mosi_stable: assert property (@(posedge rst) disable iff (clk)
    (sclk && $past(sclk)) |-> $stable(mosi))
    else begin
      fails++;
      $error("mosi changed while sclk was high");
    end

  // replies belong to a selected frame
  a_rx_in_frame: assert property (@(posedge rst) disable iff (clk) rx_done |-> !ss_n)
    else begin
      fails++;
      $error("reply strobe while slave select is released");
    end

endmodule

bind spi_byte_master tb_spi_assert u_assert (
  .rst     (rst),
  .clk     (clk),
  .sclk    (sclk_o),
  .mosi    (mosi_o),
  .ss_n    (spi_ss_n_o),
  .rx_done (spi.rx_done)
);

/* btntest_spi_top.sv */
// ---------------------------------------------------------------------------
// button driven SPI link test, stepper, sequencer and byte master
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module btntest_spi_top import gopigo_pkg::*; (
  input  logic  rst,
  input  logic  clk,
  input  logic  btn_i,
  input  logic  miso_i,
  output logic  sclk_o,
  output logic  mosi_o,
  output logic  spi_ss_n_o,
  output logic  rpi_running_o,
  output byte_t spi_rx_o,
  output logic  rx_valid_o
);

  robot_cmd_if u_cmd_if ();
  spi_byte_if  u_spi_if ();

  // button to setpoints
  btn_setpoint_stepper u_stepper (
    .rst   (rst),
    .clk   (clk),
    .btn_i (btn_i),
    .cmd   (u_cmd_if.stepper)
  );

  // setpoints to byte requests
  spi_cmd_sequencer u_seq (
    .rst           (rst),
    .clk           (clk),
    .cmd           (u_cmd_if.seq),
    .spi           (u_spi_if.ctrl),
    .rpi_running_o (rpi_running_o)
  );

  // bytes to SPI pins
  spi_byte_master u_master (
    .rst        (rst),
    .clk        (clk),
    .spi        (u_spi_if.phy),
    .sclk_o     (sclk_o),
    .mosi_o     (mosi_o),
    .miso_i     (miso_i),
    .spi_ss_n_o (spi_ss_n_o)
  );

  // last reply byte of each transfer
  assign spi_rx_o   = u_spi_if.rx_byte;
  assign rx_valid_o = u_spi_if.rx_done;

endmodule

/* spi_byte_master.sv */
// ---------------------------------------------------------------------------
// mode 0 SPI byte shifter, msb first, with slave select and reply capture
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

`include "gopigo_macros.svh"

module spi_byte_master import gopigo_pkg::*; (
  input  logic rst,
  input  logic clk,
  spi_byte_if.phy spi,
  output logic sclk_o,
  output logic mosi_o,
  input  logic miso_i,
  output logic spi_ss_n_o
);

  localparam int DIV_W = $clog2(`GOPIGO_SCLK_HALF) + 1;
  localparam int BIT_W = $clog2(`GOPIGO_BYTE_W);

  spi_state_t       state_q;
  logic [DIV_W-1:0] div_q;
  logic [BIT_W-1:0] bit_q;
  byte_t            sh_q;
  byte_t            rx_q;
  logic             sclk_q;
  logic             ss_n_q;
  logic             last_q;
  logic             half_end;
  logic             rise;
  logic             byte_end;

  assign half_end = (div_q == DIV_W'(`GOPIGO_SCLK_HALF - 1));
  // sclk about to go high, miso is sampled here
  assign rise     = (state_q == SPI_LOW) && half_end;
  // falling edge of the eighth bit
  assign byte_end = (state_q == SPI_HIGH) && half_end &&
                    (bit_q == BIT_W'(`GOPIGO_BYTE_W - 1));

  assign spi.busy = (state_q != SPI_IDLE);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q     <= SPI_IDLE;
      div_q       <= '0;
      bit_q       <= '0;
      sh_q        <= '0;
      sclk_q      <= 1'b0;
      ss_n_q      <= 1'b1;
      last_q      <= 1'b0;
      spi.rx_done <= 1'b0;
    end else begin
      spi.rx_done <= byte_end;
      case (state_q)
        SPI_IDLE: begin
          if (spi.req) begin
            sh_q    <= spi.tx_byte;
            last_q  <= spi.last;
            ss_n_q  <= 1'b0;
            div_q   <= '0;
            bit_q   <= '0;
            state_q <= SPI_LOW;
          end else if (spi.rx_done && last_q) begin
            // release one cycle after the reply strobe
            ss_n_q <= 1'b1;
          end
        end
        SPI_LOW: begin
          if (half_end) begin
            sclk_q  <= 1'b1;
            div_q   <= '0;
            state_q <= SPI_HIGH;
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        SPI_HIGH: begin
          if (half_end) begin
            sclk_q <= 1'b0;
            div_q  <= '0;
            if (byte_end) begin
              state_q <= SPI_IDLE;
            end else begin
              // next bit goes on mosi with the falling edge
              bit_q   <= bit_q + 1'b1;
              sh_q    <= {sh_q[`GOPIGO_BYTE_W-2:0], 1'b0};
              state_q <= SPI_LOW;
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // reply shift and hold
  always_ff @(posedge rst) begin
    if (rise)
      rx_q <= {rx_q[`GOPIGO_BYTE_W-2:0], miso_i};
    if (byte_end)
      spi.rx_byte <= rx_q;
  end

  assign sclk_o     = sclk_q;
  assign mosi_o     = sh_q[`GOPIGO_BYTE_W-1];
  assign spi_ss_n_o = ss_n_q;

endmodule

/* spi_cmd_sequencer.sv */
// ---------------------------------------------------------------------------
// pending field queue, frame assembly and byte by byte frame issue
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

`include "gopigo_macros.svh"

module spi_cmd_sequencer import gopigo_pkg::*; (
  input  logic rst,
  input  logic clk,
  robot_cmd_if.seq cmd,
  spi_byte_if.ctrl spi,
  output logic rpi_running_o
);

  localparam int NFLD    = 6;
  // address, command and up to three data bytes
  localparam int FRAME_W = 5 * `GOPIGO_BYTE_W;
  localparam int GAP_CYC = 2 * `GOPIGO_SCLK_HALF;
  localparam int GAP_W   = $clog2(GAP_CYC) + 1;

  seq_state_t             state_q;
  logic [NFLD-1:0]        pend_q;
  field_t                 fld_q;
  field_t                 pick_fld;
  logic [2:0]             left_q;
  logic [GAP_W-1:0]       gap_q;
  logic                   inflight_q;
  logic                   rpi_q;
  logic [FRAME_W-1:0]     frame_q;
  logic                   load;
  logic                   issue;
  logic                   byte_done;

  // lowest pending index wins
  always_comb begin
    pick_fld = FLD_DPS_LEFT;
    for (int i = NFLD - 1; i >= 0; i--) begin
      if (pend_q[i])
        pick_fld = field_t'(i);
    end
  end

  assign load      = (state_q == SEQ_LOAD);
  // next byte goes out once the previous one is fully done
  assign issue     = (state_q == SEQ_SEND) && !inflight_q && !spi.busy;
  assign byte_done = (state_q == SEQ_SEND) && inflight_q && spi.rx_done;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q    <= SEQ_IDLE;
      pend_q     <= '0;
      fld_q      <= FLD_DPS_LEFT;
      left_q     <= '0;
      gap_q      <= '0;
      inflight_q <= 1'b0;
      rpi_q      <= 1'b0;
      spi.req    <= 1'b0;
      spi.last   <= 1'b0;
    end else begin
      rpi_q   <= 1'b1;
      spi.req <= 1'b0;
      // repeated updates fold into one bit
      if (cmd.upd)
        pend_q[cmd.upd_field] <= 1'b1;
      case (state_q)
        SEQ_IDLE: begin
          if (|pend_q) begin
            fld_q   <= pick_fld;
            state_q <= SEQ_LOAD;
          end
        end
        SEQ_LOAD: begin
          // the snapshot already holds an update seen on this edge,
          // so the clear overrides the set
          pend_q[fld_q] <= 1'b0;
          if (fld_q == FLD_DPS_LEFT || fld_q == FLD_DPS_RGHT)
            left_q <= 3'd4;
          else
            left_q <= 3'd5;
          state_q <= SEQ_SEND;
        end
        SEQ_SEND: begin
          if (issue) begin
            spi.req    <= 1'b1;
            spi.last   <= (left_q == 3'd1);
            inflight_q <= 1'b1;
          end else if (byte_done) begin
            inflight_q <= 1'b0;
            left_q     <= left_q - 3'd1;
            if (spi.last) begin
              gap_q   <= '0;
              state_q <= SEQ_GAP;
            end
          end
        end
        SEQ_GAP: begin
          // ss_n stays high here
          if (gap_q == GAP_W'(GAP_CYC - 1))
            state_q <= SEQ_IDLE;
          else
            gap_q <= gap_q + 1'b1;
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // frame shift register, msb byte is the next one out
  always_ff @(posedge rst) begin
    if (load) begin
      case (fld_q)
        FLD_DPS_LEFT:
          frame_q <= {`GOPIGO_ADDR, `GOPIGO_CMD_DPS_LEFT, cmd.dps_left, byte_t'(0)};
        FLD_DPS_RGHT:
          frame_q <= {`GOPIGO_ADDR, `GOPIGO_CMD_DPS_RGHT, cmd.dps_rght, byte_t'(0)};
        FLD_EYE_LEFT:
          frame_q <= {`GOPIGO_ADDR, `GOPIGO_CMD_EYE_LEFT, cmd.eye_left};
        FLD_EYE_RGHT:
          frame_q <= {`GOPIGO_ADDR, `GOPIGO_CMD_EYE_RGHT, cmd.eye_rght};
        FLD_BLINK_LEFT:
          frame_q <= {`GOPIGO_ADDR, `GOPIGO_CMD_BLINK_LEFT, cmd.blink_left};
        FLD_BLINK_RGHT:
          frame_q <= {`GOPIGO_ADDR, `GOPIGO_CMD_BLINK_RGHT, cmd.blink_rght};
        default:
          frame_q <= '0;
      endcase
    end else if (byte_done) begin
      frame_q <= frame_q << `GOPIGO_BYTE_W;
    end
    if (issue)
      spi.tx_byte <= frame_q[FRAME_W-1 -: `GOPIGO_BYTE_W];
  end

  // tells the robot board the fpga side is alive
  assign rpi_running_o = rpi_q;

endmodule

/* btn_setpoint_stepper.sv */
// ---------------------------------------------------------------------------
// button sync and edge detect, setpoint selector and per-field step rules
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module btn_setpoint_stepper import gopigo_pkg::*; (
  input  logic rst,
  input  logic clk,
  input  logic btn_i,
  robot_cmd_if.stepper cmd
);

  // two sync stages, then the previous level for the edge
  logic btn_s1_q;
  logic btn_s2_q;
  logic btn_d_q;
  logic btn_rise;
  sel_t sel_q;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      btn_s1_q <= 1'b0;
      btn_s2_q <= 1'b0;
      btn_d_q  <= 1'b0;
    end else begin
      btn_s1_q <= btn_i;
      btn_s2_q <= btn_s1_q;
      btn_d_q  <= btn_s2_q;
    end
  end

  assign btn_rise = btn_s2_q & ~btn_d_q;

  // selector, starts on the left speed
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      sel_q <= DPS_LEFT;
    end else if (btn_rise) begin
      if (sel_q == BLINK_RGHT)
        sel_q <= PWM_LEFT;
      else
        sel_q <= sel_t'(sel_q + 4'd1);
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cmd.dps_left   <= '0;
      cmd.dps_rght   <= '0;
      cmd.eye_left   <= '0;
      cmd.eye_rght   <= '0;
      cmd.blink_left <= '0;
      cmd.blink_rght <= '0;
      cmd.upd        <= 1'b0;
      cmd.upd_field  <= FLD_DPS_LEFT;
    end else begin
      cmd.upd <= 1'b0;
      if (btn_rise) begin
        case (sel_q)
          // pwm and dps limit slots are kept but send nothing
          PWM_LEFT, PWM_RGHT, DPS_LIMIT: cmd.upd <= 1'b0;
          DPS_LEFT: begin
            if (cmd.dps_left >= dps_t'(900))
              cmd.dps_left <= '0;
            else
              cmd.dps_left <= cmd.dps_left + dps_t'(32);
            cmd.upd       <= 1'b1;
            cmd.upd_field <= FLD_DPS_LEFT;
          end
          DPS_RGHT: begin
            // 16'h8000 is above 900 so it stays there
            if (cmd.dps_rght >= dps_t'(900))
              cmd.dps_rght <= 16'h8000;
            else
              cmd.dps_rght <= cmd.dps_rght + dps_t'(400);
            cmd.upd       <= 1'b1;
            cmd.upd_field <= FLD_DPS_RGHT;
          end
          EYE_LEFT: begin
            // blue only
            if (cmd.eye_left[7:0] >= 8'd64)
              cmd.eye_left <= '0;
            else
              cmd.eye_left[7:0] <= cmd.eye_left[7:0] + 8'd32;
            cmd.upd       <= 1'b1;
            cmd.upd_field <= FLD_EYE_LEFT;
          end
          EYE_RGHT: begin
            // green only
            if (cmd.eye_rght[15:8] >= 8'd64)
              cmd.eye_rght <= '0;
            else
              cmd.eye_rght[15:8] <= cmd.eye_rght[15:8] + 8'd32;
            cmd.upd       <= 1'b1;
            cmd.upd_field <= FLD_EYE_RGHT;
          end
          BLINK_LEFT: begin
            // red only
            if (cmd.blink_left[23:16] >= 8'd128)
              cmd.blink_left <= '0;
            else
              cmd.blink_left[23:16] <= cmd.blink_left[23:16] + 8'd32;
            cmd.upd       <= 1'b1;
            cmd.upd_field <= FLD_BLINK_LEFT;
          end
          BLINK_RGHT: begin
            // all three channels step together, blue decides the clear
            if (cmd.blink_rght[7:0] >= 8'd128) begin
              cmd.blink_rght <= '0;
            end else begin
              cmd.blink_rght[7:0]   <= cmd.blink_rght[7:0] + 8'd32;
              cmd.blink_rght[15:8]  <= cmd.blink_rght[15:8] + 8'd32;
              cmd.blink_rght[23:16] <= cmd.blink_rght[23:16] + 8'd32;
            end
            cmd.upd       <= 1'b1;
            cmd.upd_field <= FLD_BLINK_RGHT;
          end
        endcase
      end
    end
  end

endmodule

/* spi_byte_if.sv */
// ---------------------------------------------------------------------------
// byte request and reply, sequencer to SPI master
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

interface spi_byte_if import gopigo_pkg::*; ();

  // request side, req is a one cycle pulse
  logic  req;
  byte_t tx_byte;
  // release slave select after this byte
  logic  last;

  // reply side
  logic  busy;
  byte_t rx_byte;
  // pulses with rx_byte at the end of every byte
  logic  rx_done;

  modport ctrl (
    output req, tx_byte, last,
    input  busy, rx_byte, rx_done
  );

  modport phy (
    input  req, tx_byte, last,
    output busy, rx_byte, rx_done
  );

endinterface

/* robot_cmd_if.sv */
// ---------------------------------------------------------------------------
// setpoint values and update strobe, stepper to sequencer
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

interface robot_cmd_if import gopigo_pkg::*; ();

  // current setpoints
  dps_t   dps_left;
  dps_t   dps_rght;
  rgb_t   eye_left;
  rgb_t   eye_rght;
  rgb_t   blink_left;
  rgb_t   blink_rght;
  // one cycle pulse, the value is already new when it is high
  logic   upd;
  field_t upd_field;

  modport stepper (
    output dps_left, dps_rght, eye_left, eye_rght, blink_left, blink_rght,
    output upd, upd_field
  );

  modport seq (
    input dps_left, dps_rght, eye_left, eye_rght, blink_left, blink_rght,
    input upd, upd_field
  );

endinterface

/* gopigo_pkg.sv */
// ---------------------------------------------------------------------------
// shared types: bytes, speeds, colors, field index and FSM encodings
// ---------------------------------------------------------------------------

`include "gopigo_macros.svh"

package gopigo_pkg;

  // one SPI byte
  typedef logic [`GOPIGO_BYTE_W-1:0] byte_t;
  // speed setpoint, 16'h8000 is the most negative value
  typedef logic [`GOPIGO_DPS_W-1:0] dps_t;
  // r in [23:16], g in [15:8], b in [7:0]
  typedef logic [`GOPIGO_RGB_W-1:0] rgb_t;
  // which of the six sent fields
  typedef logic [2:0] field_t;

  // field order, lowest index goes out first
  localparam field_t FLD_DPS_LEFT   = 3'd0;
  localparam field_t FLD_DPS_RGHT   = 3'd1;
  localparam field_t FLD_EYE_LEFT   = 3'd2;
  localparam field_t FLD_EYE_RGHT   = 3'd3;
  localparam field_t FLD_BLINK_LEFT = 3'd4;
  localparam field_t FLD_BLINK_RGHT = 3'd5;

  // selector slots, the first three are no-ops
  typedef enum logic [3:0] {
    PWM_LEFT,
    PWM_RGHT,
    DPS_LIMIT,
    DPS_LEFT,
    DPS_RGHT,
    EYE_LEFT,
    EYE_RGHT,
    BLINK_LEFT,
    BLINK_RGHT
  } sel_t;

  // frame sequencer
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LOAD,
    SEQ_SEND,
    SEQ_GAP
  } seq_state_t;

  // byte shifter, LOW and HIGH follow the SCLK level
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_LOW,
    SPI_HIGH
  } spi_state_t;

endpackage

/* gopigo_macros.svh */
// ---------------------------------------------------------------------------
// widths, SPI clock divider, robot address and command codes of the link
// ---------------------------------------------------------------------------

`ifndef GOPIGO_MACROS_SVH
`define GOPIGO_MACROS_SVH

// one byte on the wire
`define GOPIGO_BYTE_W 8
// motor speed, degrees per second
`define GOPIGO_DPS_W 16
// r g b, one byte each
`define GOPIGO_RGB_W 24

// clock cycles per SCLK half period
`define GOPIGO_SCLK_HALF 2

// address byte the robot board answers to
`define GOPIGO_ADDR 8'h08

// command byte, one per transmitted field
`define GOPIGO_CMD_DPS_LEFT 8'h0E
`define GOPIGO_CMD_DPS_RGHT 8'h0F
`define GOPIGO_CMD_EYE_LEFT 8'h10
`define GOPIGO_CMD_EYE_RGHT 8'h11
`define GOPIGO_CMD_BLINK_LEFT 8'h12
`define GOPIGO_CMD_BLINK_RGHT 8'h13

`endif
